// File: rtl/doe_pkg.sv
//----------------------------------------------------------------------
// Shared register map, widths, command codes and bundle types.
// Register addresses are byte addresses; only the low addr_width bits
// are decoded, so the map repeats above 0xFF.
//----------------------------------------------------------------------

package doe_pkg;

  //--------------------------------------------------------------------
  // Register map
  //--------------------------------------------------------------------
  localparam int addr_width = 8;

  localparam logic [addr_width-1:0] addr_ctrl     = 8'h00;
  localparam logic [addr_width-1:0] addr_status   = 8'h04;
  localparam logic [addr_width-1:0] addr_intr_sts = 8'h08;
  // IV word 0 here, words 1..3 at +4, +8, +C
  localparam logic [addr_width-1:0] addr_iv_base  = 8'h10;
  localparam int iv_words = 4;

  // CTRL fields
  localparam int ctrl_cmd_lsb  = 0;
  localparam int ctrl_dest_lsb = 2;

  // STATUS bits
  localparam int sts_ready_bit = 0;
  localparam int sts_valid_bit = 1;
  localparam int sts_error_bit = 2;

  // INTR_STS bits, write 1 to clear
  localparam int intr_error_bit = 0;
  localparam int intr_notif_bit = 1;

  //--------------------------------------------------------------------
  // Commands and datapath sizes
  //--------------------------------------------------------------------
  localparam int cmd_width = 2;
  localparam logic [cmd_width-1:0] cmd_idle  = 2'd0;
  localparam logic [cmd_width-1:0] cmd_uds   = 2'd1;
  localparam logic [cmd_width-1:0] cmd_fe    = 2'd2;
  localparam logic [cmd_width-1:0] cmd_clear = 2'd3;

  localparam int uds_blocks = 2;
  localparam int fe_blocks  = 1;

  localparam int block_width     = 128;
  localparam int half_width      = 64;
  localparam int num_rounds      = 16;
  localparam int rot_amount      = 13;
  localparam int kv_entry_width  = 5;
  localparam int kv_offset_width = 3;
  localparam int kv_data_width   = 32;

  //--------------------------------------------------------------------
  // Bundles
  //--------------------------------------------------------------------
  typedef struct packed {
    logic [cmd_width-1:0]      cmd;
    logic [kv_entry_width-1:0] dest_entry;
  } doe_cmd_t;

  // Single-cycle event pulses except busy
  typedef struct packed {
    logic busy;
    logic flow_done;
    logic error_set;
    logic clear_done;
  } doe_status_t;

  typedef struct packed {
    logic                       write_en;
    logic [kv_entry_width-1:0]  write_entry;
    logic [kv_offset_width-1:0] write_offset;
    logic [kv_data_width-1:0]   write_data;
  } kv_write_t;

  typedef struct packed {
    logic                   req;
    logic [block_width-1:0] block;
    logic [block_width-1:0] iv;
  } core_req_t;

endpackage

// File: rtl/doe_regs.sv
//----------------------------------------------------------------------
// Firmware register bank. Single-cycle cs/we bus, reads return one
// cycle later. IV words have no reset and read X until written.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module doe_regs import doe_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        cs,
  input  logic        we,
  input  logic [31:0] address,
  input  logic [31:0] write_data,
  input  doe_status_t status,
  output logic [31:0] read_data,
  output doe_cmd_t    cmd,
  output logic        cmd_valid,
  output logic [127:0] iv,
  output logic        error_intr,
  output logic        notif_intr
);

  logic [addr_width-1:0] addr;
  logic                  wr_en;
  logic                  rd_en;
  logic                  ctrl_wr;
  logic                  intr_wr;
  logic                  iv_hit;
  logic [1:0]            iv_sel;
  logic [31:0]           iv_q [iv_words];
  logic                  valid_q;
  logic [31:0]           rd_mux;

  //--------------------------------------------------------------------
  // Address decode
  //--------------------------------------------------------------------
  assign addr    = address[addr_width-1:0];
  assign wr_en   = cs && we;
  assign rd_en   = cs && !we;
  assign ctrl_wr = wr_en && (addr == addr_ctrl);
  assign intr_wr = wr_en && (addr == addr_intr_sts);
  // IV window is 16 bytes, word aligned
  assign iv_hit  = (addr[addr_width-1:4] == addr_iv_base[addr_width-1:4]) &&
                   (addr[1:0] == 2'b00);
  assign iv_sel  = addr[3:2];

  // Word 0 is the most significant
  assign iv = {iv_q[0], iv_q[1], iv_q[2], iv_q[3]};

  always_ff @(posedge clk) begin
    if (wr_en && iv_hit) begin
      iv_q[iv_sel] <= write_data;
    end
  end

  //--------------------------------------------------------------------
  // Read mux, unmapped reads 0
  //--------------------------------------------------------------------
  always_comb begin
    rd_mux = '0;
    if (iv_hit) begin
      rd_mux = iv_q[iv_sel];
    end else begin
      case (addr)
        addr_ctrl: begin
          rd_mux[ctrl_cmd_lsb +: cmd_width]       = cmd.cmd;
          rd_mux[ctrl_dest_lsb +: kv_entry_width] = cmd.dest_entry;
        end
        addr_status: begin
          rd_mux[sts_ready_bit] = !status.busy;
          rd_mux[sts_valid_bit] = valid_q;
          rd_mux[sts_error_bit] = error_intr;
        end
        addr_intr_sts: begin
          rd_mux[intr_error_bit] = error_intr;
          rd_mux[intr_notif_bit] = notif_intr;
        end
        default: ;
      endcase
    end
  end

  //--------------------------------------------------------------------
  // CTRL, sticky status and interrupt bits
  //--------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cmd        <= '0;
      cmd_valid  <= 1'b0;
      valid_q    <= 1'b0;
      error_intr <= 1'b0;
      notif_intr <= 1'b0;
      read_data  <= '0;
    end else begin
      // Only a real command starts the control FSM
      cmd_valid <= ctrl_wr && (write_data[ctrl_cmd_lsb +: cmd_width] != cmd_idle);
      if (ctrl_wr) begin
        cmd.cmd        <= write_data[ctrl_cmd_lsb +: cmd_width];
        cmd.dest_entry <= write_data[ctrl_dest_lsb +: kv_entry_width];
      end

      // New command invalidates the previous result
      if (ctrl_wr) begin
        valid_q <= 1'b0;
      end else if (status.flow_done || status.clear_done) begin
        valid_q <= 1'b1;
      end

      // Hardware set wins over a same-cycle W1C
      if (status.error_set) begin
        error_intr <= 1'b1;
      end else if (intr_wr && write_data[intr_error_bit]) begin
        error_intr <= 1'b0;
      end
      if (status.flow_done || status.clear_done) begin
        notif_intr <= 1'b1;
      end else if (intr_wr && write_data[intr_notif_bit]) begin
        notif_intr <= 1'b0;
      end

      if (rd_en) begin
        read_data <= rd_mux;
      end
    end
  end

endmodule

// File: rtl/doe_fsm.sv
//----------------------------------------------------------------------
// Flow control for UDS/FE deobfuscation. One command at a time;
// a command while busy is dropped and flagged as an error.
// CBC chaining: IV for block n+1 is ciphertext block n.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module doe_fsm import doe_pkg::*; (
  input  logic                      clk,
  input  logic                      reset_n,
  input  doe_cmd_t                  cmd,
  input  logic                      cmd_valid,
  input  logic [127:0]              iv,
  input  logic [255:0]              obf_uds_seed,
  input  logic [127:0]              obf_field_entropy,
  input  logic                      ack,
  input  logic [127:0]              result,
  input  logic                      kv_busy,
  output core_req_t                 core_req,
  output logic                      kv_start,
  output logic [127:0]              kv_block,
  output logic                      kv_block_index,
  output logic [kv_entry_width-1:0] kv_entry,
  output doe_status_t               status,
  output logic                      clear_obf_secrets
);

  typedef enum logic [2:0] {
    st_idle,
    st_request,
    st_wait_ack,
    st_release,
    st_write,
    st_done
  } fsm_state_t;

  fsm_state_t                state;
  logic                      idx_q;
  logic                      last_q;
  logic                      kv_start_q;
  logic                      clear_q;
  logic [block_width-1:0]    cur_blk_q;
  logic [block_width-1:0]    chain_iv_q;
  logic [block_width-1:0]    result_q;
  logic [kv_entry_width-1:0] entry_q;
  logic                      start;
  logic                      writer_idle;
  logic                      next_blk;

  assign start       = cmd_valid && (state == st_idle);
  // kv_busy lags kv_start by one cycle
  assign writer_idle = (state == st_write) && !kv_start_q && !kv_busy;
  assign next_blk    = writer_idle && (idx_q != last_q);

  //--------------------------------------------------------------------
  // State and control
  //--------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state      <= st_idle;
      idx_q      <= 1'b0;
      last_q     <= 1'b0;
      kv_start_q <= 1'b0;
      clear_q    <= 1'b0;
    end else begin
      kv_start_q <= 1'b0;
      clear_q    <= 1'b0;
      case (state)
        st_idle: begin
          if (cmd_valid) begin
            idx_q <= 1'b0;
            case (cmd.cmd)
              cmd_uds: begin
                last_q <= 1'(uds_blocks - 1);
                state  <= st_request;
              end
              cmd_fe: begin
                last_q <= 1'(fe_blocks - 1);
                state  <= st_request;
              end
              // CLEAR completes on its own, nothing reaches the vault
              cmd_clear: clear_q <= 1'b1;
              default: ;
            endcase
          end
        end
        st_request: state <= st_wait_ack;
        st_wait_ack: begin
          if (ack) begin
            state <= st_release;
          end
        end
        // Four-phase: wait for ack low before any further req
        st_release: begin
          if (!ack) begin
            kv_start_q <= 1'b1;
            state      <= st_write;
          end
        end
        st_write: begin
          if (next_blk) begin
            idx_q <= idx_q + 1'b1;
            state <= st_request;
          end else if (writer_idle) begin
            state <= st_done;
          end
        end
        st_done: state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  //--------------------------------------------------------------------
  // Block, chained IV and result
  //--------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (start) begin
      entry_q    <= cmd.dest_entry;
      chain_iv_q <= iv;
      // UDS high half decrypts first
      cur_blk_q  <= (cmd.cmd == cmd_uds) ? obf_uds_seed[255:128] : obf_field_entropy;
    end else if (next_blk) begin
      chain_iv_q <= cur_blk_q;
      cur_blk_q  <= obf_uds_seed[127:0];
    end
    if (state == st_wait_ack && ack) begin
      result_q <= result;
    end
  end

  //--------------------------------------------------------------------
  // Outputs
  //--------------------------------------------------------------------
  assign core_req.req   = (state == st_request) || (state == st_wait_ack);
  assign core_req.block = cur_blk_q;
  assign core_req.iv    = chain_iv_q;

  assign kv_start       = kv_start_q;
  assign kv_block       = result_q;
  assign kv_block_index = idx_q;
  assign kv_entry       = entry_q;

  assign status.busy       = (state != st_idle);
  assign status.flow_done  = (state == st_done);
  assign status.error_set  = cmd_valid && (state != st_idle);
  assign status.clear_done = clear_q;

  assign clear_obf_secrets = clear_q;

endmodule

// File: rtl/doe_cbc_core.sv
//----------------------------------------------------------------------
// Iterative 16-round Feistel decrypt, one round per cycle, result XOR
// iv. Stand-in for an AES core. Block and iv must stay stable while
// req is high; ack comes 17 cycles after req is sampled.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module doe_cbc_core import doe_pkg::*; (
  input  logic                   clk,
  input  logic                   reset_n,
  input  core_req_t              core_req,
  input  logic [block_width-1:0] key,
  output logic                   ack,
  output logic [block_width-1:0] result
);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_out,
    st_ack
  } core_state_t;

  core_state_t           state;
  logic [3:0]            rnd_q;
  logic [half_width-1:0] left_q;
  logic [half_width-1:0] right_q;
  logic [half_width-1:0] rkey;
  logic [half_width-1:0] f_out;

  // F(x, k) = x + rotl(x ^ k, 13)
  function automatic logic [half_width-1:0] round_fn(
    input logic [half_width-1:0] x,
    input logic [half_width-1:0] k
  );
    logic [half_width-1:0] mix;
    mix = x ^ k;
    return x + {mix[half_width-1-rot_amount:0],
                mix[half_width-1:half_width-rot_amount]};
  endfunction

  // Even rounds use key high half, odd rounds low half
  assign rkey  = (rnd_q[0] ? key[half_width-1:0] : key[block_width-1:half_width]) ^
                 half_width'(rnd_q);
  assign f_out = round_fn(left_q, rkey);

  //--------------------------------------------------------------------
  // Handshake and round sequencing
  //--------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= st_idle;
      rnd_q <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (core_req.req) begin
            rnd_q <= 4'(num_rounds - 1);
            state <= st_run;
          end
        end
        // Rounds undone from 15 down to 0
        st_run: begin
          rnd_q <= rnd_q - 1'b1;
          if (rnd_q == '0) begin
            state <= st_out;
          end
        end
        st_out: state <= st_ack;
        st_ack: begin
          if (!core_req.req) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  //--------------------------------------------------------------------
  // Datapath
  //--------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (state == st_idle && core_req.req) begin
      left_q  <= core_req.block[block_width-1:half_width];
      right_q <= core_req.block[half_width-1:0];
    end else if (state == st_run) begin
      // Inverse of L' = R, R' = L ^ F(R)
      left_q  <= right_q ^ f_out;
      right_q <= left_q;
    end
    // iv still held by requester here
    if (state == st_out) begin
      result <= {left_q, right_q} ^ core_req.iv;
    end
  end

  assign ack = (state == st_ack);

endmodule

// File: rtl/doe_kv_writer.sv
//----------------------------------------------------------------------
// Splits one 128-bit block into four dword key vault writes, MSB
// dword first, offset = block index * 4 + dword. kv_start while
// busy is ignored.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module doe_kv_writer import doe_pkg::*; (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      kv_start,
  input  logic [block_width-1:0]    kv_block,
  input  logic                      kv_block_index,
  input  logic [kv_entry_width-1:0] kv_entry,
  output logic                      kv_busy,
  output kv_write_t                 kv_write
);

  logic                      busy_q;
  logic [1:0]                cnt_q;
  logic                      idx_q;
  logic [kv_entry_width-1:0] entry_q;
  logic [block_width-1:0]    shift_q;
  logic                      load;

  assign load = kv_start && !busy_q;

  // Dword counter, one write per cycle while busy
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (load) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (busy_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == 2'd3) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      shift_q <= kv_block;
      idx_q   <= kv_block_index;
      entry_q <= kv_entry;
    end else if (busy_q) begin
      shift_q <= {shift_q[block_width-kv_data_width-1:0], {kv_data_width{1'b0}}};
    end
  end

  assign kv_busy = busy_q;

  assign kv_write.write_en     = busy_q;
  assign kv_write.write_entry  = entry_q;
  assign kv_write.write_offset = {idx_q, cnt_q};
  assign kv_write.write_data   = shift_q[block_width-1 -: kv_data_width];

endmodule

// File: rtl/doe_cbc.sv
//----------------------------------------------------------------------
// Deobfuscation engine top. Obfuscation key and seeds must be static
// while a flow runs. No key vault back-pressure.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module doe_cbc import doe_pkg::*; (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic [block_width-1:0] cptra_obf_key,
  input  logic [255:0]           obf_uds_seed,
  input  logic [block_width-1:0] obf_field_entropy,
  input  logic                   cs,
  input  logic                   we,
  input  logic [31:0]            address,
  input  logic [31:0]            write_data,
  output logic [31:0]            read_data,
  output logic                   error_intr,
  output logic                   notif_intr,
  output logic                   clear_obf_secrets,
  output kv_write_t              kv_write
);

  doe_cmd_t                  cmd;
  logic                      cmd_valid;
  logic [block_width-1:0]    iv;
  doe_status_t               status;
  core_req_t                 core_req;
  logic                      ack;
  logic [block_width-1:0]    result;
  logic                      kv_start;
  logic                      kv_busy;
  logic [block_width-1:0]    kv_block;
  logic                      kv_block_index;
  logic [kv_entry_width-1:0] kv_entry;

  //--------------------------------------------------------------------
  // Firmware registers
  //--------------------------------------------------------------------
  doe_regs i_doe_regs (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .status     (status),
    .read_data  (read_data),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .iv         (iv),
    .error_intr (error_intr),
    .notif_intr (notif_intr)
  );

  // Flow sequencing
  doe_fsm i_doe_fsm (
    .clk               (clk),
    .reset_n           (reset_n),
    .cmd               (cmd),
    .cmd_valid         (cmd_valid),
    .iv                (iv),
    .obf_uds_seed      (obf_uds_seed),
    .obf_field_entropy (obf_field_entropy),
    .ack               (ack),
    .result            (result),
    .kv_busy           (kv_busy),
    .core_req          (core_req),
    .kv_start          (kv_start),
    .kv_block          (kv_block),
    .kv_block_index    (kv_block_index),
    .kv_entry          (kv_entry),
    .status            (status),
    .clear_obf_secrets (clear_obf_secrets)
  );

  // Block decrypt under the fused key
  doe_cbc_core i_doe_cbc_core (
    .clk      (clk),
    .reset_n  (reset_n),
    .core_req (core_req),
    .key      (cptra_obf_key),
    .ack      (ack),
    .result   (result)
  );

  doe_kv_writer i_doe_kv_writer (
    .clk            (clk),
    .reset_n        (reset_n),
    .kv_start       (kv_start),
    .kv_block       (kv_block),
    .kv_block_index (kv_block_index),
    .kv_entry       (kv_entry),
    .kv_busy        (kv_busy),
    .kv_write       (kv_write)
  );

endmodule

// File: verification/doe_cbc_checker.sv
//----------------------------------------------------------------------
// Watches key vault writes, clear pulses and interrupts. Outputs are
// sampled on the falling edge and each vault write is matched in
// order against the expected queue as it appears.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module doe_cbc_checker import doe_pkg::*; (
  input logic      clk,
  input kv_write_t kv_write,
  input logic      clear_obf_secrets,
  input logic      error_intr,
  input logic      notif_intr
);

  string     test_name;
  int        test_errs;
  int        exp_clears;
  int        pass_cnt;
  int        fail_cnt;
  kv_write_t exp_q[$];
  int        clear_cnt;
  int        clear_base;

  // Compare every vault write and count every clear cycle
  always @(negedge clk) begin
    if (kv_write.write_en) begin
      compare_write(kv_write);
    end
    if (clear_obf_secrets) begin
      clear_cnt++;
    end
  end

  //----------------------------------------------------------------------
  // Test bookkeeping
  //----------------------------------------------------------------------
  task automatic start_test(input string name, input int clears);
    test_name = name;
    test_errs = 0;
    exp_clears = clears;
    clear_base = clear_cnt;
    exp_q.delete();
  endtask

  task automatic expect_write(input logic [4:0] entry, input logic [2:0] offset,
                              input logic [31:0] data);
    kv_write_t e;
    e.write_en = 1'b1;
    e.write_entry = entry;
    e.write_offset = offset;
    e.write_data = data;
    exp_q.push_back(e);
  endtask

  // Failure without an expected and actual value
  task automatic report_failure(input string msg);
    $display("%s: %s", test_name, msg);
    test_errs++;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("error %s: %s expected %h actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_intr(input logic exp_error, input logic exp_notif);
    check_value("error_intr", 32'(exp_error), 32'(error_intr));
    check_value("notif_intr", 32'(exp_notif), 32'(notif_intr));
  endtask

  // Oldest expected write against the one on the port
  task automatic compare_write(input kv_write_t act);
    kv_write_t want;
    if (exp_q.size() == 0) begin
      report_failure($sformatf("unexpected key vault write to entry %0d offset %0d",
                               act.write_entry, act.write_offset));
    end else begin
      want = exp_q.pop_front();
      check_value($sformatf("kv write data at offset %0d", want.write_offset),
                  want.write_data, act.write_data);
      check_value("kv write entry/offset",
                  32'({want.write_entry, want.write_offset}),
                  32'({act.write_entry, act.write_offset}));
    end
  endtask

  task automatic end_test();
    if (exp_q.size() != 0) begin
      report_failure($sformatf("%0d expected key vault writes never appeared",
                               exp_q.size()));
    end
    exp_q.delete();
    if (clear_cnt - clear_base != exp_clears) begin
      report_failure($sformatf("clear_obf_secrets was high for %0d cycles instead of %0d",
                               clear_cnt - clear_base, exp_clears));
    end
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %s: passed", test_name);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", test_name, test_errs);
    end
  endtask

endmodule

// File: verification/doe_cbc_tb.sv
//----------------------------------------------------------------------
// Testbench top for the deobfuscation engine. Bus and seed inputs
// change 2 ns after the rising edge and every wait polls STATUS with
// its own timeout. Key vault and interrupt checks live in the checker.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module doe_cbc_tb import doe_pkg::*; ();

  localparam int timeout_cycles = 2000;

  logic         clk;
  logic         reset_n;
  logic [127:0] cptra_obf_key;
  logic [255:0] obf_uds_seed;
  logic [127:0] obf_field_entropy;
  logic         cs;
  logic         we;
  logic [31:0]  address;
  logic [31:0]  write_data;
  logic [31:0]  read_data;
  logic         error_intr;
  logic         notif_intr;
  logic         clear_obf_secrets;
  kv_write_t    kv_write;

  logic [31:0]  seed;
  logic [127:0] iv_val;
  logic         timed_out;

  doe_cbc i_dut (
    .clk               (clk),
    .reset_n           (reset_n),
    .cptra_obf_key     (cptra_obf_key),
    .obf_uds_seed      (obf_uds_seed),
    .obf_field_entropy (obf_field_entropy),
    .cs                (cs),
    .we                (we),
    .address           (address),
    .write_data        (write_data),
    .read_data         (read_data),
    .error_intr        (error_intr),
    .notif_intr        (notif_intr),
    .clear_obf_secrets (clear_obf_secrets),
    .kv_write          (kv_write)
  );

  doe_cbc_checker i_checker (
    .clk               (clk),
    .kv_write          (kv_write),
    .clear_obf_secrets (clear_obf_secrets),
    .error_intr        (error_intr),
    .notif_intr        (notif_intr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //----------------------------------------------------------------------
  // Reference model
  //----------------------------------------------------------------------
  // Round function x + rotl(x ^ k, 13)
  function automatic logic [63:0] feistel_f(input logic [63:0] x, input logic [63:0] k);
    logic [63:0] m;
    m = x ^ k;
    return x + {m[50:0], m[63:51]};
  endfunction

  // Undo encrypt rounds 15 down to 0 with L = R' ^ F(L') and R = L'
  function automatic logic [127:0] doe_ref_decrypt(input logic [127:0] blk,
                                                   input logic [127:0] key);
    logic [63:0] l;
    logic [63:0] r;
    logic [63:0] rk;
    logic [63:0] t;
    int          rnd;
    l = blk[127:64];
    r = blk[63:0];
    for (rnd = 15; rnd >= 0; rnd--) begin
      rk = ((rnd % 2) == 1) ? key[63:0] : key[127:64];
      rk = rk ^ 64'(rnd);
      t  = l;
      l  = r ^ feistel_f(t, rk);
      r  = t;
    end
    return {l, r};
  endfunction

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] status_word(input logic ready, input logic valid,
                                              input logic error);
    logic [31:0] s;
    s = '0;
    s[sts_ready_bit] = ready;
    s[sts_valid_bit] = valid;
    s[sts_error_bit] = error;
    return s;
  endfunction

  //----------------------------------------------------------------------
  // Stimulus helpers
  //----------------------------------------------------------------------
  task automatic next_word(output logic [31:0] v);
    seed = lcg_step(seed);
    v = seed;
  endtask

  task automatic rand128(output logic [127:0] v);
    logic [31:0] x;
    int          i;
    v = '0;
    for (i = 0; i < 4; i++) begin
      next_word(x);
      v = {v[95:0], x};
    end
  endtask

  task automatic write_reg(input logic [addr_width-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    #2;
    cs = 1'b1;
    we = 1'b1;
    address = 32'(addr);
    write_data = data;
    @(posedge clk);
    #2;
    cs = 1'b0;
    we = 1'b0;
  endtask

  // Read data is registered and sampled after the capture edge
  task automatic read_reg(input logic [addr_width-1:0] addr, output logic [31:0] data);
    @(posedge clk);
    #2;
    cs = 1'b1;
    we = 1'b0;
    address = 32'(addr);
    @(posedge clk);
    #2;
    cs = 1'b0;
    data = read_data;
  endtask

  task automatic start_cmd(input logic [1:0] c, input logic [4:0] entry);
    logic [31:0] ctrl;
    ctrl = '0;
    ctrl[ctrl_cmd_lsb +: cmd_width] = c;
    ctrl[ctrl_dest_lsb +: kv_entry_width] = entry;
    write_reg(addr_ctrl, ctrl);
  endtask

  // New key, seeds and IV while the engine is idle
  task automatic randomize_inputs();
    logic [127:0] k;
    logic [127:0] u_hi;
    logic [127:0] u_lo;
    logic [127:0] f;
    int           i;
    rand128(k);
    rand128(u_hi);
    rand128(u_lo);
    rand128(f);
    rand128(iv_val);
    @(posedge clk);
    #2;
    cptra_obf_key = k;
    obf_uds_seed = {u_hi, u_lo};
    obf_field_entropy = f;
    // IV word 0 is the most significant
    for (i = 0; i < 4; i++) begin
      write_reg(addr_iv_base + 8'(4 * i), iv_val[127 - 32 * i -: 32]);
    end
  endtask

  // Four dwords per block MSB first at offset index * 4 + dword
  task automatic queue_block(input logic [4:0] entry, input int idx, input logic [127:0] pt);
    int d;
    for (d = 0; d < 4; d++) begin
      i_checker.expect_write(entry, 3'(idx * 4 + d), pt[127 - 32 * d -: 32]);
    end
  endtask

  // CBC chaining with the register IV, then with the first ciphertext
  task automatic push_expected(input logic [1:0] c, input logic [4:0] entry);
    logic [127:0] pt;
    if (c == cmd_uds) begin
      pt = doe_ref_decrypt(obf_uds_seed[255:128], cptra_obf_key) ^ iv_val;
      queue_block(entry, 0, pt);
      pt = doe_ref_decrypt(obf_uds_seed[127:0], cptra_obf_key) ^ obf_uds_seed[255:128];
      queue_block(entry, 1, pt);
    end else begin
      pt = doe_ref_decrypt(obf_field_entropy, cptra_obf_key) ^ iv_val;
      queue_block(entry, 0, pt);
    end
  endtask

  task automatic wait_valid();
    logic [31:0] s;
    logic        seen;
    int          cycles;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < timeout_cycles) begin
      read_reg(addr_status, s);
      seen = s[sts_valid_bit];
      cycles += 2;
    end
    if (!seen) begin
      i_checker.report_failure($sformatf("STATUS VALID did not set within %0d cycles",
                                         timeout_cycles));
      timed_out = 1'b1;
    end
  endtask

  task automatic run_flow(input logic [1:0] c, input logic [4:0] entry);
    logic [31:0] s;
    push_expected(c, entry);
    write_reg(addr_intr_sts, 32'h3);
    start_cmd(c, entry);
    wait_valid();
    if (!timed_out) begin
      i_checker.check_intr(1'b0, 1'b1);
      read_reg(addr_status, s);
      i_checker.check_value("STATUS", status_word(1'b1, 1'b1, 1'b0), s);
    end
  endtask

  //----------------------------------------------------------------------
  // Test sequence
  //----------------------------------------------------------------------
  // Stops at the first test that times out
  task automatic run_tests();
    logic [31:0] rd;
    logic [31:0] w;
    logic [1:0]  c;
    int          k;

    i_checker.start_test("reset_state", 0);
    read_reg(addr_status, rd);
    i_checker.check_value("STATUS", status_word(1'b1, 1'b0, 1'b0), rd);
    i_checker.check_intr(1'b0, 1'b0);
    i_checker.end_test();

    i_checker.start_test("fe_decrypt", 0);
    randomize_inputs();
    next_word(w);
    run_flow(cmd_fe, 5'(w));
    i_checker.end_test();
    if (timed_out) begin
      return;
    end

    i_checker.start_test("uds_chaining", 0);
    randomize_inputs();
    next_word(w);
    run_flow(cmd_uds, 5'(w));
    i_checker.end_test();
    if (timed_out) begin
      return;
    end

    // Second command lands mid-flow and must be dropped
    i_checker.start_test("busy_rejection", 0);
    randomize_inputs();
    next_word(w);
    push_expected(cmd_uds, 5'(w));
    write_reg(addr_intr_sts, 32'h3);
    start_cmd(cmd_uds, 5'(w));
    repeat (5) @(posedge clk);
    start_cmd(cmd_fe, 5'(w >> 8));
    wait_valid();
    if (!timed_out) begin
      i_checker.check_intr(1'b1, 1'b1);
      read_reg(addr_status, rd);
      i_checker.check_value("STATUS", status_word(1'b1, 1'b1, 1'b1), rd);
      write_reg(addr_intr_sts, 32'h3);
      i_checker.check_intr(1'b0, 1'b0);
    end
    i_checker.end_test();
    if (timed_out) begin
      return;
    end

    i_checker.start_test("clear", 1);
    write_reg(addr_intr_sts, 32'h3);
    start_cmd(cmd_clear, 5'd0);
    wait_valid();
    if (!timed_out) begin
      i_checker.check_intr(1'b0, 1'b1);
    end
    i_checker.end_test();
    if (timed_out) begin
      return;
    end

    for (k = 0; k < 8; k++) begin
      i_checker.start_test($sformatf("random_flow_%0d", k), 0);
      randomize_inputs();
      next_word(w);
      c = w[0] ? cmd_uds : cmd_fe;
      run_flow(c, 5'(w >> 1));
      i_checker.end_test();
      if (timed_out) begin
        return;
      end
    end
  endtask

  initial begin
    reset_n = 1'b0;
    cs = 1'b0;
    we = 1'b0;
    address = '0;
    write_data = '0;
    cptra_obf_key = '0;
    obf_uds_seed = '0;
    obf_field_entropy = '0;
    iv_val = '0;
    timed_out = 1'b0;
    seed = 32'h2158221b;
    repeat (4) @(posedge clk);
    #2;
    reset_n = 1'b1;

    run_tests();

    $display("tests passed: %0d, tests failed: %0d", i_checker.pass_cnt, i_checker.fail_cnt);
    if (!timed_out && i_checker.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: doe_cbc.f
rtl/doe_pkg.sv
rtl/doe_regs.sv
rtl/doe_fsm.sv
rtl/doe_cbc_core.sv
rtl/doe_kv_writer.sv
rtl/doe_cbc.sv
verification/doe_cbc_checker.sv
verification/doe_cbc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the doe_cbc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --top-module doe_cbc_tb -f doe_cbc.f

out=$(./obj_dir/Vdoe_cbc_tb)
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1
